//--- common/oled_pkg.sv
package oled_pkg;

    ////////////////////////////////////////
    // Panel and font geometry
    ////////////////////////////////////////

    localparam int PAGES          = 4;    // 8-pixel rows on the 32-line panel
    localparam int CHARS_PER_PAGE = 16;
    localparam int GLYPH_COLS     = 8;    // Column bytes per character
    localparam int GLYPH_COUNT    = 17;   // Digits, A to F, blank
    localparam int BLANK_GLYPH    = 16;   // Last font entry

    localparam logic [7:0] SPACE_CODE = 8'h20;

    ////////////////////////////////////////
    // SSD1306 command bytes
    ////////////////////////////////////////

    // Sent once at power-up with DC low
    localparam logic [0:16][7:0] INIT_CMDS = {
        8'hAE,          // Display off
        8'hD5, 8'h80,   // Clock divide
        8'hA8, 8'h1F,   // Multiplex ratio of 32 lines
        8'h8D, 8'h14,   // Charge pump on
        8'hD9, 8'hFF,   // Precharge period
        8'hDB, 8'h40,   // VCOMH level
        8'h81, 8'hF1,   // Contrast
        8'hA0, 8'hC0,   // Segment and COM scan direction
        8'hDA, 8'h02    // COM pin layout
    };

    localparam logic [7:0] CMD_SET_PAGE   = 8'h22;
    localparam logic [7:0] CMD_COL_LOW    = 8'h00;  // Column start low nibble
    localparam logic [7:0] CMD_COL_HIGH   = 8'h10;  // Column start high nibble
    localparam logic [7:0] CMD_DISPLAY_ON = 8'hAF;

    ////////////////////////////////////////
    // Timing
    ////////////////////////////////////////

    localparam int SPI_HALF_CYCLES    = 2;    // CLK cycles per SCLK half period
    localparam int POWER_DELAY_CYCLES = 200;  // Shortened power sequencing wait

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    typedef logic [7:0] char_t;
    typedef logic [1:0] page_idx_t;
    typedef logic [3:0] col_idx_t;

    // Line p is text[p], character 0 sits in the top byte of its line
    typedef logic [PAGES-1:0][CHARS_PER_PAGE*8-1:0] screen_text_t;

    typedef struct packed {
        logic sdin;
        logic sclk;
        logic dc;     // Low for command, high for data
        logic res;    // Active low panel reset
        logic vbat;   // Active low panel supply
        logic vdd;    // Active low logic supply
    } oled_pins_t;

    typedef struct packed {
        logic       start;
        logic [7:0] data;
    } spi_cmd_t;

    typedef struct packed {
        logic      load;
        logic      fill;
        page_idx_t page;
        col_idx_t  col;
    } buf_ctrl_t;

endpackage

//--- screen/screen_buffer.sv
`timescale 1ns/100ps

module screen_buffer (
    input  logic                   CLK,
    input  logic                   RST_IN,
    input  oled_pkg::screen_text_t text,
    input  oled_pkg::buf_ctrl_t    ctrl,
    output oled_pkg::char_t        char_out
);

    // 4 lines of 16 character codes
    oled_pkg::char_t store [oled_pkg::PAGES][oled_pkg::CHARS_PER_PAGE];

    ////////////////////////////////////////
    // Fill and load
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RST_IN || ctrl.fill) begin                       // Blank screen
            for (int p = 0; p < oled_pkg::PAGES; p++) begin
                for (int c = 0; c < oled_pkg::CHARS_PER_PAGE; c++) begin
                    store[p][c] <= oled_pkg::SPACE_CODE;
                end
            end
        end else if (ctrl.load) begin
            for (int p = 0; p < oled_pkg::PAGES; p++) begin
                for (int c = 0; c < oled_pkg::CHARS_PER_PAGE; c++) begin
                    // Leftmost character is the top byte
                    store[p][c] <= text[p][(oled_pkg::CHARS_PER_PAGE - 1 - c) * 8 +: 8];
                end
            end
        end
    end

    // Registered read, one cycle after the address
    always_ff @(posedge CLK) begin
        char_out <= store[ctrl.page][ctrl.col];
    end

endmodule

//--- screen/glyph_rom.sv
`timescale 1ns/100ps

module glyph_rom (
    input  logic            CLK,
    input  oled_pkg::char_t char_in,
    input  logic [2:0]      col,
    output logic [7:0]      glyph_byte
);

    logic [7:0] font [0:oled_pkg::GLYPH_COUNT*oled_pkg::GLYPH_COLS-1];
    logic [4:0] glyph_idx;

    initial $readmemh("screen/font.mem", font);   // Eight bytes per glyph line

    // Hex digits only, the rest draw blank
    always_comb begin
        if (char_in >= 8'h30 && char_in <= 8'h39) begin          // '0' to '9'
            glyph_idx = 5'(char_in - 8'h30);
        end else if (char_in >= 8'h41 && char_in <= 8'h46) begin // 'A' to 'F'
            glyph_idx = 5'(char_in - 8'h41 + 8'd10);
        end else begin
            glyph_idx = 5'(oled_pkg::BLANK_GLYPH);
        end
    end

    always_ff @(posedge CLK) begin
        glyph_byte <= font[{glyph_idx, col}];
    end

endmodule

//--- design/spi_shifter.sv
`timescale 1ns/100ps

module spi_shifter (
    input  logic               CLK,
    input  logic               RST_IN,
    input  oled_pkg::spi_cmd_t spi,
    output logic               sdin,
    output logic               sclk,
    output logic               done
);

    typedef logic [$clog2(oled_pkg::SPI_HALF_CYCLES)-1:0] half_t;

    logic       busy;
    half_t      half_cnt;   // CLK cycles within a half period
    logic [3:0] edge_cnt;   // 16 SCLK edges per byte
    logic [7:0] shreg;
    logic       half_end;

    assign half_end = (half_cnt == half_t'(oled_pkg::SPI_HALF_CYCLES - 1));

    ////////////////////////////////////////
    // SCLK and SDIN generation
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RST_IN) begin
            busy     <= 1'b0;
            half_cnt <= '0;
            edge_cnt <= '0;
            sclk     <= 1'b1;   // Idles high
            sdin     <= 1'b0;
        end else if (!busy) begin
            if (spi.start) begin   // Start while busy is ignored
                busy     <= 1'b1;
                half_cnt <= '0;
                edge_cnt <= '0;
            end
        end else if (half_end) begin
            half_cnt <= '0;
            edge_cnt <= edge_cnt + 1'b1;
            sclk     <= ~sclk;
            if (sclk) sdin <= shreg[7];          // Falling edge, MSB first
            if (edge_cnt == 4'd15) busy <= 1'b0; // 8th rising edge
        end else begin
            half_cnt <= half_cnt + half_t'(1);
        end
    end

    always_ff @(posedge CLK) begin
        if (!busy && spi.start) begin
            shreg <= spi.data;
        end else if (busy && half_end && sclk) begin
            shreg <= {shreg[6:0], 1'b0};
        end
    end

    assign done = busy && half_end && (edge_cnt == 4'd15);

endmodule

//--- sequencer/oled_sequencer.sv
`timescale 1ns/100ps

module oled_sequencer (
    input  logic                CLK,
    input  logic                RST_IN,
    input  logic                clear,
    input  logic                refresh,
    input  logic                spi_done,
    input  logic [7:0]          glyph_byte,
    output oled_pkg::spi_cmd_t  spi,
    output oled_pkg::buf_ctrl_t buf_ctrl,
    output logic [2:0]          glyph_col,
    output logic                dc,
    output logic                res,
    output logic                vbat,
    output logic                vdd
);

    typedef enum logic [3:0] {
        S_VDD_ON,
        S_INIT,
        S_VBAT_ON,
        S_RES_LOW,
        S_RES_OFF,
        S_DELAY,
        S_SPI_WAIT,
        S_IDLE,
        S_PAGE,
        S_DRAW,
        S_DISP_ON
    } state_t;

    typedef logic [$clog2(oled_pkg::POWER_DELAY_CYCLES)-1:0] delay_t;

    state_t              state;
    state_t              ret_state;   // Where to go after a byte or a wait
    logic [4:0]          step;        // Init list or page header index
    delay_t              delay_cnt;
    oled_pkg::page_idx_t page;
    oled_pkg::col_idx_t  col;
    logic [2:0]          gcol;        // Column byte within the glyph
    logic                disp_on;
    logic                load_q;
    logic                fill_q;
    logic                clear_r;
    logic                refresh_r;
    logic [7:0]          hdr_byte;

    always_ff @(posedge CLK) begin
        if (RST_IN) begin
            clear_r   <= 1'b0;
            refresh_r <= 1'b0;
        end else begin
            clear_r   <= clear;
            refresh_r <= refresh;
        end
    end

    // Page setup bytes
    always_comb begin
        case (step[1:0])
            2'd0:    hdr_byte = oled_pkg::CMD_SET_PAGE;
            2'd1:    hdr_byte = {6'b000000, page};
            2'd2:    hdr_byte = oled_pkg::CMD_COL_LOW;
            default: hdr_byte = oled_pkg::CMD_COL_HIGH;
        endcase
    end

    ////////////////////////////////////////
    // Main FSM
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RST_IN) begin
            state     <= S_VDD_ON;
            ret_state <= S_IDLE;
            step      <= '0;
            delay_cnt <= '0;
            page      <= '0;
            col       <= '0;
            gcol      <= '0;
            disp_on   <= 1'b0;
            load_q    <= 1'b0;
            fill_q    <= 1'b0;
            spi.start <= 1'b0;
            dc        <= 1'b0;
            res       <= 1'b0;
            vbat      <= 1'b1;   // Supplies off
            vdd       <= 1'b1;
        end else begin
            spi.start <= 1'b0;
            load_q    <= 1'b0;
            fill_q    <= 1'b0;
            case (state)
                S_VDD_ON: begin
                    vdd       <= 1'b0;
                    res       <= 1'b1;
                    ret_state <= S_INIT;
                    state     <= S_DELAY;
                end
                S_INIT: begin
                    spi.start <= 1'b1;
                    spi.data  <= oled_pkg::INIT_CMDS[step];
                    state     <= S_SPI_WAIT;
                    if (step == 5'($size(oled_pkg::INIT_CMDS) - 1)) begin
                        step      <= '0;
                        ret_state <= S_VBAT_ON;
                    end else begin
                        step      <= step + 1'b1;
                        ret_state <= S_INIT;
                    end
                end
                S_VBAT_ON: begin
                    vbat      <= 1'b0;
                    ret_state <= S_RES_LOW;
                    state     <= S_DELAY;
                end
                S_RES_LOW: begin
                    res       <= 1'b0;   // Held for one full wait
                    ret_state <= S_RES_OFF;
                    state     <= S_DELAY;
                end
                S_RES_OFF: begin
                    res    <= 1'b1;
                    fill_q <= 1'b1;      // Start-up clear
                    state  <= S_PAGE;
                end
                S_DELAY: begin
                    if (delay_cnt == delay_t'(oled_pkg::POWER_DELAY_CYCLES - 1)) begin
                        delay_cnt <= '0;
                        state     <= ret_state;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                S_SPI_WAIT: if (spi_done) state <= ret_state;
                S_IDLE: begin
                    if (refresh_r) begin          // Refresh wins over clear
                        load_q <= 1'b1;
                        state  <= S_PAGE;
                    end else if (clear_r) begin
                        fill_q <= 1'b1;
                        state  <= S_PAGE;
                    end
                end
                S_PAGE: begin
                    dc        <= 1'b0;
                    spi.start <= 1'b1;
                    spi.data  <= hdr_byte;
                    state     <= S_SPI_WAIT;
                    if (step == 5'd3) begin
                        step      <= '0;
                        ret_state <= S_DRAW;
                    end else begin
                        step      <= step + 1'b1;
                        ret_state <= S_PAGE;
                    end
                end
                S_DRAW: begin
                    dc        <= 1'b1;
                    spi.start <= 1'b1;
                    spi.data  <= glyph_byte;
                    state     <= S_SPI_WAIT;
                    // Next address goes out now, the read settles while this byte shifts
                    gcol <= gcol + 1'b1;
                    if (gcol == 3'd7) col <= col + 1'b1;
                    if (gcol != 3'd7 || col != 4'd15) begin
                        ret_state <= S_DRAW;
                    end else begin
                        page <= page + 1'b1;   // Wraps back to page 0
                        if (page != 2'd3)  ret_state <= S_PAGE;
                        else if (!disp_on) ret_state <= S_DISP_ON;
                        else               ret_state <= S_IDLE;
                    end
                end
                S_DISP_ON: begin
                    dc        <= 1'b0;
                    spi.start <= 1'b1;
                    spi.data  <= oled_pkg::CMD_DISPLAY_ON;
                    disp_on   <= 1'b1;
                    ret_state <= S_IDLE;
                    state     <= S_SPI_WAIT;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign buf_ctrl  = '{load: load_q, fill: fill_q, page: page, col: col};
    assign glyph_col = gcol;

endmodule

//--- design/oled_top.sv
`timescale 1ns/100ps

module oled_top (
    input  logic                   CLK,
    input  logic                   RST_IN,
    input  oled_pkg::screen_text_t text,
    input  logic                   clear,
    input  logic                   refresh,
    output oled_pkg::oled_pins_t   pins
);

    oled_pkg::spi_cmd_t  spi;
    oled_pkg::buf_ctrl_t buf_ctrl;
    oled_pkg::char_t     char_code;   // Buffer to ROM
    logic [2:0]          glyph_col;
    logic [7:0]          glyph_byte;
    logic                spi_done;
    logic                sdin;
    logic                sclk;
    logic                dc;
    logic                res;
    logic                vbat;
    logic                vdd;

    oled_sequencer i_oled_sequencer (
        .CLK        (CLK),
        .RST_IN     (RST_IN),
        .clear      (clear),
        .refresh    (refresh),
        .spi_done   (spi_done),
        .glyph_byte (glyph_byte),
        .spi        (spi),
        .buf_ctrl   (buf_ctrl),
        .glyph_col  (glyph_col),
        .dc         (dc),
        .res        (res),
        .vbat       (vbat),
        .vdd        (vdd)
    );

    screen_buffer i_screen_buffer (
        .CLK      (CLK),
        .RST_IN   (RST_IN),
        .text     (text),
        .ctrl     (buf_ctrl),
        .char_out (char_code)
    );

    glyph_rom i_glyph_rom (
        .CLK        (CLK),
        .char_in    (char_code),
        .col        (glyph_col),
        .glyph_byte (glyph_byte)
    );

    spi_shifter i_spi_shifter (
        .CLK    (CLK),
        .RST_IN (RST_IN),
        .spi    (spi),
        .sdin   (sdin),
        .sclk   (sclk),
        .done   (spi_done)
    );

    assign pins = '{sdin: sdin, sclk: sclk, dc: dc, res: res, vbat: vbat, vdd: vdd};

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic CLK,
    output logic RST_IN
);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;   // 4 ns period
    end

    // Reset held for 16 rising edges
    initial begin
        RST_IN = 1'b1;
        repeat (16) @(posedge CLK);
        RST_IN <= 1'b0;
    end

endmodule

//--- verification/oled_chk.sv
`timescale 1ns/100ps

module oled_chk (
    input logic                 CLK,
    input logic                 RST_IN,
    input oled_pkg::oled_pins_t pins,
    input oled_pkg::spi_cmd_t   spi,
    input logic                 spi_done
);

    logic        in_flight;       // From the cycle after start up to done
    logic        drawn;           // First data byte has gone out
    int unsigned fail_count = 0;

    always_ff @(posedge CLK) begin
        if (RST_IN) begin
            in_flight <= 1'b0;
            drawn     <= 1'b0;
        end else begin
            if (spi.start) in_flight <= 1'b1;
            else if (spi_done) in_flight <= 1'b0;
            if (spi_done && pins.dc) drawn <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // Panel pin rules
    ////////////////////////////////////////

    dc_stable: assert property (@(posedge CLK) disable iff (RST_IN)
        in_flight |-> $stable(pins.dc))
        else begin
            $error("dc changed while a byte was in flight");
            fail_count = fail_count + 1;
        end

    // Panel supply only with logic supply on
    vbat_order: assert property (@(posedge CLK) disable iff (RST_IN)
        !pins.vbat |-> !pins.vdd)
        else begin
            $error("vbat is on while vdd is off");
            fail_count = fail_count + 1;
        end

    res_quiet: assert property (@(posedge CLK) disable iff (RST_IN)
        drawn |-> !$fell(pins.res))
        else begin
            $error("res fell after the first drawn byte");
            fail_count = fail_count + 1;
        end

    sclk_idle: assert property (@(posedge CLK) disable iff (RST_IN)
        !in_flight |-> pins.sclk)
        else begin
            $error("sclk left its idle level with no byte in flight");
            fail_count = fail_count + 1;
        end

endmodule

//--- verification/oled_tb.sv
`timescale 1ns/100ps

module oled_tb;

    typedef struct packed {
        logic [7:0] data;
        logic       dc;
        logic       res;
        logic       vbat;
        logic       vdd;
    } byte_rec_t;

    // One row of the stimulus table
    typedef struct packed {
        logic       refresh;
        logic       clear;
        logic [1:0] text_sel;       // 0 and 1 fixed lines, 2 random hex
        logic       expect_blank;
    } op_t;

    logic                   CLK;
    logic                   RST_IN;
    oled_pkg::screen_text_t text;
    logic                   clear;
    logic                   refresh;
    oled_pkg::oled_pins_t   pins;

    logic [7:0]  font [0:oled_pkg::GLYPH_COUNT*oled_pkg::GLYPH_COLS-1];
    byte_rec_t   byte_q [$];
    int          res_fall_at [$];   // Byte count when res went low
    int          byte_count = 0;
    int          bit_cnt = 0;
    logic [7:0]  shift = '0;
    logic        prev_sclk = 1'b1;
    logic        prev_res = 1'b0;
    logic [31:0] rng_state;
    op_t         op_table [6];

    tb_clock i_tb_clock (.CLK(CLK), .RST_IN(RST_IN));

    oled_top i_oled_top (
        .CLK     (CLK),
        .RST_IN  (RST_IN),
        .text    (text),
        .clear   (clear),
        .refresh (refresh),
        .pins    (pins)
    );

    bind oled_top oled_chk i_oled_chk (
        .CLK      (CLK),
        .RST_IN   (RST_IN),
        .pins     (pins),
        .spi      (spi),
        .spi_done (spi_done)
    );

    task automatic abort_run(input string why);
        $display("%s at %0t", why, $time);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Font line for a character code
    function automatic int glyph_of(input logic [7:0] code);
        if (code >= 8'h30 && code <= 8'h39) return int'(code - 8'h30);
        if (code >= 8'h41 && code <= 8'h46) return int'(code - 8'h41) + 10;
        return oled_pkg::BLANK_GLYPH;
    endfunction

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        return (n < 4'd10) ? 8'h30 + 8'(n) : 8'h41 + 8'(n) - 8'd10;
    endfunction

    function automatic oled_pkg::screen_text_t fixed_text(input logic [1:0] sel);
        oled_pkg::screen_text_t t;
        if (sel == 2'd0) begin
            t[0] = "HELLO 0123456789";
            t[1] = "ABCDEF-abcdef+42";
            t[2] = "  DEADBEEF  C0DE";
            t[3] = "0000111122223333";
        end else begin
            t[0] = "FEDCBA9876543210";
            t[1] = "x=1F y=2E z=3D!!";
            t[2] = "CAFE  BABE  F00D";
            t[3] = "9 8 7 6 5 4 3 2 ";
        end
        return t;
    endfunction

    task automatic fill_table();
        op_table[0] = '{1'b1, 1'b0, 2'd0, 1'b0};   // Refresh with fixed text
        op_table[1] = '{1'b0, 1'b1, 2'd0, 1'b1};   // Clear after a refresh
        op_table[2] = '{1'b1, 1'b0, 2'd2, 1'b0};
        op_table[3] = '{1'b1, 1'b1, 2'd1, 1'b0};   // Both at once, refresh wins
        op_table[4] = '{1'b0, 1'b1, 2'd1, 1'b1};
        op_table[5] = '{1'b1, 1'b0, 2'd2, 1'b0};
    endtask

    ////////////////////////////////////////
    // Byte monitor
    ////////////////////////////////////////

    // Pins settle on the rising CLK edge, so they are read on the falling one
    always @(negedge CLK) begin
        if (RST_IN) begin
            prev_sclk = 1'b1;
            prev_res  = 1'b0;
            bit_cnt   = 0;
        end else begin
            if (pins.sclk && !prev_sclk) begin
                shift = {shift[6:0], pins.sdin};
                bit_cnt++;
                if (bit_cnt == 8) begin
                    byte_q.push_back('{shift, pins.dc, pins.res, pins.vbat, pins.vdd});
                    byte_count++;
                    bit_cnt = 0;
                end
            end
            if (prev_res && !pins.res) res_fall_at.push_back(byte_count);
            prev_sclk = pins.sclk;
            prev_res  = pins.res;
        end
        check_value("assertion failures", i_oled_top.i_oled_chk.fail_count, 32'd0);
    end

    task automatic wait_bytes(input int count, input string what);
        int cycles;
        cycles = 0;
        while (byte_q.size() < count) begin
            @(posedge CLK);
            cycles++;
            if (cycles > count * 48 + 2000) abort_run({"timeout waiting for ", what});
        end
    endtask

    task automatic check_reset_pins();
        int cycles;
        cycles = 0;
        @(posedge CLK);   // First edge applies reset to the DUT
        // Last pass lands just after release, before the FSM has moved
        while (RST_IN) begin
            @(negedge CLK);
            cycles++;
            if (cycles > 64) abort_run("reset was never released");
            check_value("vdd", pins.vdd, 1'b1);
            check_value("vbat", pins.vbat, 1'b1);
            check_value("res", pins.res, 1'b0);
            check_value("sclk", pins.sclk, 1'b1);
        end
    endtask

    task automatic expect_byte(input logic [7:0] exp_data, input logic exp_dc,
                               input logic exp_vbat);
        byte_rec_t rec;
        if (byte_q.size() == 0) abort_run("a byte was expected but none was captured");
        rec = byte_q.pop_front();
        check_value("sdin byte", rec.data, exp_data);
        check_value("dc", rec.dc, exp_dc);
        check_value("vdd", rec.vdd, 1'b0);
        check_value("vbat", rec.vbat, exp_vbat);
        check_value("res", rec.res, 1'b1);
    endtask

    task automatic expect_pages(input oled_pkg::screen_text_t txt);
        logic [7:0] code;
        int         row;
        for (int p = 0; p < oled_pkg::PAGES; p++) begin
            expect_byte(oled_pkg::CMD_SET_PAGE, 1'b0, 1'b0);
            expect_byte(8'(p), 1'b0, 1'b0);
            expect_byte(oled_pkg::CMD_COL_LOW, 1'b0, 1'b0);
            expect_byte(oled_pkg::CMD_COL_HIGH, 1'b0, 1'b0);
            for (int c = 0; c < oled_pkg::CHARS_PER_PAGE; c++) begin
                code = txt[p][127 - 8*c -: 8];   // Character 0 is the top byte
                row  = glyph_of(code) * oled_pkg::GLYPH_COLS;
                for (int g = 0; g < oled_pkg::GLYPH_COLS; g++) begin
                    expect_byte(font[row + g], 1'b1, 1'b0);
                end
            end
        end
    endtask

    task automatic check_startup();
        int n_init;
        n_init = $size(oled_pkg::INIT_CMDS);
        wait_bytes(n_init + 4 * 132 + 1, "the start-up sequence");
        for (int i = 0; i < n_init; i++) begin
            expect_byte(oled_pkg::INIT_CMDS[i], 1'b0, 1'b1);   // Panel supply still off
        end
        check_value("res falls", res_fall_at.size(), 32'd1);
        check_value("bytes before res pulse", res_fall_at[0], n_init);
        expect_pages({64{oled_pkg::SPACE_CODE}});
        expect_byte(oled_pkg::CMD_DISPLAY_ON, 1'b0, 1'b0);
    endtask

    task automatic run_op(input op_t op);
        oled_pkg::screen_text_t txt;
        oled_pkg::screen_text_t exp_txt;
        if (op.text_sel == 2'd2) begin
            for (int p = 0; p < oled_pkg::PAGES; p++) begin
                for (int c = 0; c < oled_pkg::CHARS_PER_PAGE; c++) begin
                    rng_state = next_random(rng_state);
                    txt[p][127 - 8*c -: 8] = hex_char(rng_state[3:0]);
                end
            end
        end else begin
            txt = fixed_text(op.text_sel);
        end
        exp_txt = op.expect_blank ? {64{oled_pkg::SPACE_CODE}} : txt;
        @(posedge CLK);
        text    <= txt;
        refresh <= op.refresh;
        clear   <= op.clear;
        wait_bytes(1, "the first byte of a request");
        refresh <= 1'b0;   // Request taken, a level held to the end is drawn again
        clear   <= 1'b0;
        wait_bytes(4 * 132, "a full screen");
        expect_pages(exp_txt);
        repeat (100) @(posedge CLK);   // No second screen may follow
        check_value("bytes after a screen", byte_q.size(), 32'd0);
    endtask

    initial begin
        text      = '0;
        clear     = 1'b0;
        refresh   = 1'b0;
        rng_state = 32'hc33dea61;
        fill_table();
        $readmemh("screen/font.mem", font);
        check_reset_pins();
        check_startup();
        foreach (op_table[i]) run_op(op_table[i]);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- screen/font.mem
// One glyph per line, eight column bytes from left to right, bit 0 is the top pixel
// Lines 0 to 9 are the digits, 10 to 15 the letters A to F, line 16 is blank
00 3E 51 49 45 3E 00 00
00 00 42 7F 40 00 00 00
00 42 61 51 49 46 00 00
00 21 41 45 4B 31 00 00
00 18 14 12 7F 10 00 00
00 27 45 45 45 39 00 00
00 3C 4A 49 49 30 00 00
00 01 71 09 05 03 00 00
00 36 49 49 49 36 00 00
00 06 49 49 29 1E 00 00
00 7E 11 11 11 7E 00 00
00 7F 49 49 49 36 00 00
00 3E 41 41 41 22 00 00
00 7F 41 41 22 1C 00 00
00 7F 49 49 49 41 00 00
00 7F 09 09 09 01 00 00
00 00 00 00 00 00 00 00

//--- compile.f
common/oled_pkg.sv
screen/screen_buffer.sv
screen/glyph_rom.sv
design/spi_shifter.sv
sequencer/oled_sequencer.sv
design/oled_top.sv
verification/tb_clock.sv
verification/oled_chk.sv
verification/oled_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = oled_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = TESTBENCH PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
